/* glm_pkg.sv */
package glm_pkg;

    // **************************************************
    // fixed-point format and sizes
    // **************************************************
    localparam int LANES            = 4;
    localparam int LANE_WIDTH       = 16;
    localparam int FRAC_BITS        = 8;
    localparam int MODEL_DEPTH_LOG2 = 8;
    localparam int MODEL_DEPTH      = 1 << MODEL_DEPTH_LOG2;
    localparam int COUNT_WIDTH      = 16;

    // **************************************************
    // datapath types
    // **************************************************
    // one signed lane, also the gradient scalar
    typedef logic signed [LANE_WIDTH-1:0] lane_t;

    // lanes packed with lane 0 in the low bits
    typedef logic [LANES*LANE_WIDTH-1:0] line_t;

    typedef logic [MODEL_DEPTH_LOG2-1:0] model_addr_t;
    typedef logic [COUNT_WIDTH-1:0] count_t;

    typedef enum logic
    {
        idle,
        run
    } scale_state_t;

endpackage

/* glm_update_top.sv */
`timescale 1ns/1ns

module glm_update_top import glm_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        op_start,
    input  count_t      num_lines,
    input  count_t      num_iterations,
    input  model_addr_t model_offset,
    input  logic        line_valid,
    input  line_t       line_data,
    input  lane_t       gradient,
    input  logic        load_we,
    input  model_addr_t load_addr,
    input  line_t       load_data,
    output logic        model_we,
    output model_addr_t model_waddr,
    output line_t       model_wdata,
    output logic        op_done
);
    // **************************************************
    // stage links and memory read port
    // **************************************************
    line_bus_if scaled_bus ();
    line_bus_if fetched_bus ();

    model_addr_t ram_raddr;
    line_t       ram_rdata;

    scale_stage u_scale_stage
    (
        .clk            (clk),
        .reset          (reset),
        .op_start       (op_start),
        .num_lines      (num_lines),
        .num_iterations (num_iterations),
        .model_offset   (model_offset),
        .line_valid     (line_valid),
        .line_data      (line_data),
        .gradient       (gradient),
        .scaled         (scaled_bus.source)
    );

    model_fetch_stage u_model_fetch_stage
    (
        .clk     (clk),
        .reset   (reset),
        .scaled  (scaled_bus.sink),
        .fetched (fetched_bus.source),
        .raddr   (ram_raddr),
        .rdata   (ram_rdata),
        .wb_we   (model_we),
        .wb_addr (model_waddr),
        .wb_data (model_wdata)
    );

    // update write goes to the memory and out of the top
    model_update_stage u_model_update_stage
    (
        .clk     (clk),
        .reset   (reset),
        .fetched (fetched_bus.sink),
        .we      (model_we),
        .waddr   (model_waddr),
        .wdata   (model_wdata),
        .op_done (op_done)
    );

    model_ram u_model_ram
    (
        .clk       (clk),
        .load_we   (load_we),
        .load_addr (load_addr),
        .load_data (load_data),
        .raddr     (ram_raddr),
        .rdata     (ram_rdata),
        .we        (model_we),
        .waddr     (model_waddr),
        .wdata     (model_wdata)
    );

endmodule

/* line_bus_if.sv */
`timescale 1ns/1ns

interface line_bus_if import glm_pkg::*; ();

    logic        valid;
    line_t       data;
    // second line, only carried between fetch and update
    line_t       operand;
    model_addr_t addr;
    // final line of the final iteration
    logic        last;

    modport source
    (
        output valid,
        output data,
        output operand,
        output addr,
        output last
    );

    modport sink
    (
        input valid,
        input data,
        input operand,
        input addr,
        input last
    );

endinterface

/* model_fetch_stage.sv */
`timescale 1ns/1ns

module model_fetch_stage import glm_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    line_bus_if.sink    scaled,
    line_bus_if.source  fetched,
    output model_addr_t raddr,
    input  line_t       rdata,
    input  logic        wb_we,
    input  model_addr_t wb_addr,
    input  line_t       wb_data
);
    logic        valid_q;
    logic        last_q;
    model_addr_t addr_q;
    line_t       operand_q;

    // write landing on the same edge as our read
    logic  hold_hit;
    line_t hold_data;

    // write of the line right before this one
    logic near_hit;

    assign raddr = scaled.addr;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            valid_q <= 1'b0;
            last_q <= 1'b0;
            hold_hit <= 1'b0;
        end
        else
        begin
            valid_q <= scaled.valid;
            last_q <= scaled.valid && scaled.last;
            hold_hit <= wb_we && (wb_addr == scaled.addr);
        end

        addr_q <= scaled.addr;
        operand_q <= scaled.data;
        hold_data <= wb_data;
    end

    // **************************************************
    // read-after-write forwarding
    // **************************************************
    // the write visible now is newer than the held one,
    // and neither has reached the memory read yet
    assign near_hit = wb_we && (wb_addr == addr_q);

    assign fetched.data    = near_hit ? wb_data : (hold_hit ? hold_data : rdata);
    assign fetched.valid   = valid_q;
    assign fetched.operand = operand_q;
    assign fetched.addr    = addr_q;
    assign fetched.last    = last_q;

endmodule

/* model_ram.sv */
`timescale 1ns/1ns

module model_ram import glm_pkg::*;
(
    input  logic        clk,
    input  logic        load_we,
    input  model_addr_t load_addr,
    input  line_t       load_data,
    input  model_addr_t raddr,
    output line_t       rdata,
    input  logic        we,
    input  model_addr_t waddr,
    input  line_t       wdata
);
    line_t mem [MODEL_DEPTH];

    // single write port, load has priority over update
    always_ff @(posedge clk)
    begin
        if (load_we)
        begin
            mem[load_addr] <= load_data;
        end
        else if (we)
        begin
            mem[waddr] <= wdata;
        end
    end

    // read returns the old line on a same-cycle write
    always_ff @(posedge clk)
    begin
        rdata <= mem[raddr];
    end

endmodule

/* model_update_stage.sv */
`timescale 1ns/1ns

module model_update_stage import glm_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    line_bus_if.sink    fetched,
    output logic        we,
    output model_addr_t waddr,
    output line_t       wdata,
    output logic        op_done
);
    line_t difference;

    // model minus scaled sample, wrapping per lane
    always_comb
    begin
        for (int i = 0; i < LANES; i++)
        begin
            difference[i*LANE_WIDTH +: LANE_WIDTH] =
                fetched.data[i*LANE_WIDTH +: LANE_WIDTH]
                - fetched.operand[i*LANE_WIDTH +: LANE_WIDTH];
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            we <= 1'b0;
            op_done <= 1'b0;
        end
        else
        begin
            we <= fetched.valid;
            // done goes out together with the final write
            op_done <= fetched.valid && fetched.last;
        end

        waddr <= fetched.addr;
        wdata <= difference;
    end

endmodule

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --top-module tb_glm_update -f sim.f

# the simulation exits non-zero on failure, the log decides
./obj_dir/Vtb_glm_update > sim.log 2>&1 || true

if grep -q "TESTBENCH PASSED" sim.log
then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi

/* scale_stage.sv */
`timescale 1ns/1ns

module scale_stage import glm_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        op_start,
    input  count_t      num_lines,
    input  count_t      num_iterations,
    input  model_addr_t model_offset,
    input  logic        line_valid,
    input  line_t       line_data,
    input  lane_t       gradient,
    line_bus_if.source  scaled
);
    scale_state_t state;

    // configuration latched on start
    count_t      num_lines_q;
    count_t      num_iterations_q;
    model_addr_t offset_q;
    lane_t       gradient_q;

    count_t line_count;
    count_t iteration_count;

    logic  accept;
    logic  first_line;
    logic  last_line;
    logic  last_iteration;
    lane_t gradient_now;

    logic signed [2*LANE_WIDTH-1:0] product [LANES];
    line_t scaled_line;

    logic        valid_q;
    line_t       data_q;
    model_addr_t addr_q;
    logic        last_q;

    assign accept         = (state == run) && line_valid;
    assign first_line     = (line_count == '0);
    assign last_line      = (line_count == num_lines_q - 1'b1);
    assign last_iteration = (iteration_count == num_iterations_q - 1'b1);

    // first line of an iteration takes the port value directly
    assign gradient_now = first_line ? gradient : gradient_q;

    // **************************************************
    // lane multiply, Q8.8 times Q8.8 back to Q8.8
    // **************************************************
    always_comb
    begin
        for (int i = 0; i < LANES; i++)
        begin
            product[i] = lane_t'(line_data[i*LANE_WIDTH +: LANE_WIDTH]) * gradient_now;
            // shift by the fraction, keep the low lane bits
            scaled_line[i*LANE_WIDTH +: LANE_WIDTH] = product[i][FRAC_BITS +: LANE_WIDTH];
        end
    end

    // **************************************************
    // line and iteration control
    // **************************************************
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= idle;
            valid_q <= 1'b0;
            last_q <= 1'b0;
        end
        else
        begin
            valid_q <= accept;
            last_q <= accept && last_line && last_iteration;

            case (state)
                idle:
                begin
                    if (op_start)
                    begin
                        num_lines_q <= num_lines;
                        num_iterations_q <= num_iterations;
                        offset_q <= model_offset;
                        line_count <= '0;
                        iteration_count <= '0;
                        state <= run;
                    end
                end

                run:
                begin
                    if (accept)
                    begin
                        if (first_line)
                        begin
                            gradient_q <= gradient;
                        end
                        if (last_line)
                        begin
                            line_count <= '0;
                            iteration_count <= iteration_count + 1'b1;
                            if (last_iteration)
                            begin
                                state <= idle;
                            end
                        end
                        else
                        begin
                            line_count <= line_count + 1'b1;
                        end
                    end
                end

                default:
                begin
                    state <= idle;
                end
            endcase
        end

        data_q <= scaled_line;
        // address wraps within the model memory
        addr_q <= offset_q + line_count[MODEL_DEPTH_LOG2-1:0];
    end

    assign scaled.valid   = valid_q;
    assign scaled.data    = data_q;
    assign scaled.operand = '0;
    assign scaled.addr    = addr_q;
    assign scaled.last    = last_q;

endmodule

/* sim.f */
glm_pkg.sv
line_bus_if.sv
scale_stage.sv
model_ram.sv
model_fetch_stage.sv
model_update_stage.sv
glm_update_top.sv
tb_glm_update.sv

/* tb_glm_update.sv */
`timescale 1ns/1ns

module tb_glm_update import glm_pkg::*;
();
    // one row of the test table
    typedef struct packed
    {
        count_t      lines;
        count_t      iterations;
        model_addr_t offset;
        lane_t [3:0] grads;
        logic        random_gap;
        logic        extreme;
        logic        load;
    } test_row_t;

    logic        clk;
    logic        reset;
    logic        op_start;
    count_t      num_lines;
    count_t      num_iterations;
    model_addr_t model_offset;
    logic        line_valid;
    line_t       line_data;
    lane_t       gradient;
    logic        load_we;
    model_addr_t load_addr;
    line_t       load_data;
    logic        model_we;
    model_addr_t model_waddr;
    line_t       model_wdata;
    logic        op_done;

    test_row_t   tests [$];
    string       test_names [$];
    logic        table_ready;
    string       test_name;
    logic [31:0] rng;

    // mirror of the model memory
    line_t ref_mem [MODEL_DEPTH];

    // expected writes in flight
    // slot 2 falls due at the current falling edge
    logic        exp_we [3];
    logic        exp_done [3];
    model_addr_t exp_addr [3];
    line_t       exp_data [3];

    glm_update_top UUT
    (
        .clk            (clk),
        .reset          (reset),
        .op_start       (op_start),
        .num_lines      (num_lines),
        .num_iterations (num_iterations),
        .model_offset   (model_offset),
        .line_valid     (line_valid),
        .line_data      (line_data),
        .gradient       (gradient),
        .load_we        (load_we),
        .load_addr      (load_addr),
        .load_data      (load_data),
        .model_we       (model_we),
        .model_waddr    (model_waddr),
        .model_wdata    (model_wdata),
        .op_done        (op_done)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // **************************************************
    // failure reporting and compare tasks
    // **************************************************
    task automatic fail_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_line(input string what, input line_t expected, input line_t actual);
        if (actual !== expected)
        begin
            $display("** Error: test %s, %s expected %h, actual %h",
                     test_name, what, expected, actual);
            fail_run();
        end
    endtask

    task automatic check_addr(input string what, input model_addr_t expected,
                              input model_addr_t actual);
        if (actual !== expected)
        begin
            $display("** Error: test %s, %s expected %h, actual %h",
                     test_name, what, expected, actual);
            fail_run();
        end
    endtask

    task automatic check_bit(input string what, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("** Error: test %s, %s expected %b, actual %b",
                     test_name, what, expected, actual);
            fail_run();
        end
    endtask

    // **************************************************
    // random data and reference model
    // **************************************************
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic random_lane(input logic extreme, output lane_t lane);
        rng = xorshift32(rng);
        if (extreme)
        begin
            case (rng[1:0])
                2'd0: lane = 16'sh7fff;
                2'd1: lane = 16'sh8000;
                2'd2: lane = 16'shffff;
                default: lane = 16'sh0001;
            endcase
        end
        else
        begin
            lane = rng[15:0];
        end
    endtask

    task automatic make_line(input logic extreme, output line_t line);
        lane_t lane;
        for (int i = 0; i < LANES; i++)
        begin
            random_lane(extreme, lane);
            line[i*LANE_WIDTH +: LANE_WIDTH] = lane;
        end
    endtask

    // Q8.8 product shifted arithmetically and truncated to 16 bits
    function automatic lane_t scale_lane(input lane_t sample, input lane_t grad);
        int prod;
        prod = int'(sample) * int'(grad);
        return lane_t'(prod >>> FRAC_BITS);
    endfunction

    function automatic line_t updated_line(input line_t model, input line_t sample,
                                           input lane_t grad);
        line_t result;
        lane_t m;
        lane_t s;
        for (int i = 0; i < LANES; i++)
        begin
            m = model[i*LANE_WIDTH +: LANE_WIDTH];
            s = scale_lane(sample[i*LANE_WIDTH +: LANE_WIDTH], grad);
            result[i*LANE_WIDTH +: LANE_WIDTH] = m - s;
        end
        return result;
    endfunction

    // **************************************************
    // cycle stepping
    // **************************************************
    task automatic tick();
        @(negedge clk);
        check_bit("model_we", exp_we[2], model_we);
        check_bit("op_done", exp_done[2], op_done);
        if (exp_we[2])
        begin
            check_addr("model_waddr", exp_addr[2], model_waddr);
            check_line("model_wdata", exp_data[2], model_wdata);
        end
        for (int i = 2; i > 0; i--)
        begin
            exp_we[i] = exp_we[i-1];
            exp_done[i] = exp_done[i-1];
            exp_addr[i] = exp_addr[i-1];
            exp_data[i] = exp_data[i-1];
        end
        exp_we[0] = 1'b0;
        exp_done[0] = 1'b0;
    endtask

    task automatic clear_inputs();
        op_start = 1'b0;
        line_valid = 1'b0;
        load_we = 1'b0;
    endtask

    task automatic load_model(input test_row_t row);
        model_addr_t addr;
        line_t       data;
        for (int k = 0; k < int'(row.lines); k++)
        begin
            tick();
            clear_inputs();
            addr = row.offset + model_addr_t'(k);
            make_line(row.extreme, data);
            load_we = 1'b1;
            load_addr = addr;
            load_data = data;
            ref_mem[addr] = data;
        end
    endtask

    task automatic run_test(input int t);
        test_row_t   row;
        int          sent;
        int          gap;
        model_addr_t addr;
        line_t       sample;
        lane_t       noise;
        row = tests[t];
        test_name = test_names[t];
        sent = 0;
        if (row.load)
        begin
            load_model(row);
        end

        // strobe while idle
        tick();
        clear_inputs();
        make_line(row.extreme, sample);
        line_valid = 1'b1;
        line_data = sample;

        tick();
        clear_inputs();
        op_start = 1'b1;
        num_lines = row.lines;
        num_iterations = row.iterations;
        model_offset = row.offset;

        for (int it = 0; it < int'(row.iterations); it++)
        begin
            for (int k = 0; k < int'(row.lines); k++)
            begin
                if (row.random_gap)
                begin
                    rng = xorshift32(rng);
                    gap = int'(rng[1:0]);
                    repeat (gap)
                    begin
                        tick();
                        clear_inputs();
                    end
                end
                tick();
                clear_inputs();
                make_line(row.extreme, sample);
                addr = row.offset + model_addr_t'(k);
                line_valid = 1'b1;
                line_data = sample;
                // gradient port only counts on the first line
                if (k == 0)
                begin
                    gradient = row.grads[it];
                end
                else
                begin
                    random_lane(1'b0, noise);
                    gradient = noise;
                end
                // restart attempt while busy
                if (sent == 1)
                begin
                    op_start = 1'b1;
                    num_lines = 16'd1;
                    num_iterations = 16'd1;
                    model_offset = row.offset + 8'd77;
                end
                ref_mem[addr] = updated_line(ref_mem[addr], sample, row.grads[it]);
                exp_we[0] = 1'b1;
                exp_addr[0] = addr;
                exp_data[0] = ref_mem[addr];
                exp_done[0] = (it == int'(row.iterations) - 1) && (k == int'(row.lines) - 1);
                sent++;
            end
        end

        // strobe after the last line
        tick();
        clear_inputs();
        make_line(row.extreme, sample);
        line_valid = 1'b1;
        line_data = sample;
        repeat (4)
        begin
            tick();
            clear_inputs();
        end
    endtask

    // **************************************************
    // test table
    // **************************************************
    task automatic add_test(input string name, input int lines, input int iterations,
                            input int offset, input lane_t g0, input lane_t g1,
                            input lane_t g2, input lane_t g3, input int random_gap,
                            input int extreme, input int load);
        test_row_t row;
        row.lines = count_t'(lines);
        row.iterations = count_t'(iterations);
        row.offset = model_addr_t'(offset);
        row.grads[0] = g0;
        row.grads[1] = g1;
        row.grads[2] = g2;
        row.grads[3] = g3;
        row.random_gap = (random_gap != 0);
        row.extreme = (extreme != 0);
        row.load = (load != 0);
        tests.push_back(row);
        test_names.push_back(name);
    endtask

    task automatic fill_table();
        // name, lines, iterations, offset, gradient per iteration, gap, extreme, load
        add_test("single_update", 8, 1, 16, 16'sh0180, 16'sh0000, 16'sh0000, 16'sh0000, 0, 0, 1);
        add_test("multi_iter", 6, 4, 40, 16'sh0100, 16'shff80, 16'sh0240, 16'shfe00, 0, 0, 1);
        add_test("one_line", 1, 4, 100, 16'sh0040, 16'sh0300, 16'shff00, 16'sh0080, 0, 0, 1);
        add_test("two_lines", 2, 3, 120, 16'shff40, 16'sh0123, 16'shfd80, 16'sh0000, 0, 0, 1);
        add_test("random_gaps", 10, 3, 60, 16'sh0155, 16'shfe80, 16'sh0200, 16'sh0000, 1, 0, 1);
        add_test("offset_wrap", 8, 2, 252, 16'sh7fff, 16'sh8000, 16'sh0000, 16'sh0000, 0, 1, 1);
        // keeps the model written by the row before
        add_test("wrap_reuse", 8, 3, 252, 16'shfff0, 16'sh8000, 16'shff01, 16'sh0000, 1, 1, 0);
        table_ready = 1'b1;
    endtask

    initial
    begin : watchdog
        int limit;
        wait (table_ready);
        limit = 10;
        foreach (tests[i])
        begin
            limit += 20 + 4 * int'(tests[i].lines) * int'(tests[i].iterations);
        end
        repeat (limit) @(posedge clk);
        $display("watchdog: the run did not finish within %0d clock cycles", limit);
        fail_run();
    end

    initial
    begin
        reset = 1'b1;
        op_start = 1'b0;
        num_lines = '0;
        num_iterations = '0;
        model_offset = '0;
        line_valid = 1'b0;
        line_data = '0;
        gradient = '0;
        load_we = 1'b0;
        load_addr = '0;
        load_data = '0;
        rng = 32'h1949;
        table_ready = 1'b0;
        test_name = "reset";
        for (int i = 0; i < 3; i++)
        begin
            exp_we[i] = 1'b0;
            exp_done[i] = 1'b0;
            exp_addr[i] = '0;
            exp_data[i] = '0;
        end
        fill_table();

        repeat (10) @(negedge clk);
        reset = 1'b0;

        for (int t = 0; t < tests.size(); t++)
        begin
            run_test(t);
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule
